// ==== src/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

  // Byte address width of the wide port.
  localparam int unsigned AddrWidth = 16;
  // Data width of the wide port.
  localparam int unsigned DataWidth = 64;
  // One strobe bit per data byte.
  localparam int unsigned StrbWidth = DataWidth / 8;
  // Wide transactions that may be outstanding at once.
  localparam int unsigned MaxTrans  = 4;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] wide_data_t;
  typedef logic [StrbWidth-1:0] wide_strb_t;

  // Counts transactions held in the zero-strobe tracker, up to MaxTrans+1.
  typedef logic [$clog2(MaxTrans+2)-1:0] trans_cnt_t;

  // One request on the wide port.
  typedef struct packed {
    addr_t      addr;
    wide_data_t wdata;
    wide_strb_t strb;
    logic       we;
  } mem_req_t;

  // Wide response, rdata only meaningful for reads.
  typedef struct packed {
    wide_data_t rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== src/bank_pkg.sv ====
`default_nettype none

package bank_pkg;

  import mem_bus_pkg::addr_t;

  // Banks side by side across the wide word.
  localparam int unsigned NumBanks      = 4;
  localparam int unsigned BankDataWidth = 16;
  localparam int unsigned BankStrbWidth = BankDataWidth / 8;
  // Words stored in each bank.
  localparam int unsigned BankWords     = 256;
  // Depth of the per-bank request and response FIFOs.
  localparam int unsigned FifoDepth     = 2;
  // Lowest address bit of the word index, above bank and byte offsets.
  localparam int unsigned WordLsb       = $clog2(NumBanks * BankStrbWidth);

  typedef logic [BankDataWidth-1:0]       bank_data_t;
  typedef logic [BankStrbWidth-1:0]       bank_strb_t;
  typedef logic [NumBanks-1:0]            bank_mask_t;
  typedef logic [$clog2(BankWords)-1:0]   word_idx_t;
  // Responses a bank may owe, 0 up to FifoDepth.
  typedef logic [$clog2(FifoDepth+1)-1:0] credit_t;

  // One bank request, the address is the full byte address.
  typedef struct packed {
    addr_t      addr;
    bank_data_t wdata;
    bank_strb_t strb;
    logic       we;
  } bank_req_t;

  typedef struct packed {
    bank_data_t rdata;
  } bank_rsp_t;

endpackage

`default_nettype wire

// ==== src/stream_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module stream_fifo #(
  parameter int unsigned WIDTH = 8,
  parameter int unsigned DEPTH = 2
) (
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire logic [WIDTH-1:0] data_i,
  input  wire logic             valid_i,
  output logic                  ready_o,
  output logic      [WIDTH-1:0] data_o,
  output logic                  valid_o,
  input  wire logic             ready_i
);

  localparam int unsigned PtrWidth = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CntWidth = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]    mem_q [DEPTH];
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [CntWidth-1:0] cnt_q;
  logic                empty;
  logic                push;
  logic                pop;

  // Wrap a pointer at DEPTH, which need not be a power of two.
  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty   = (cnt_q == '0);
  assign ready_o = (cnt_q < CntWidth'(DEPTH));

  // Empty FIFO hands the input straight to the output.
  assign valid_o = empty ? valid_i : 1'b1;
  assign data_o  = empty ? data_i : mem_q[rd_ptr_q];

  // Store only what the consumer does not take in passing.
  assign push = valid_i && ready_o && !(empty && ready_i);
  assign pop  = !empty && ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Storage, no reset.
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Producer must never offer data that the FIFO cannot take.
  a_no_push_when_full : assert property (@(posedge clk_i) disable iff (rst_i)
    valid_i |-> ready_o)
    else $error("stream_fifo push while full");

  a_cnt_in_range : assert property (@(posedge clk_i) disable iff (rst_i)
    cnt_q <= CntWidth'(DEPTH))
    else $error("stream_fifo occupancy above depth");

endmodule

`default_nettype wire

// ==== src/bank_sram.sv ====
`timescale 1ns/1ns
`default_nettype none

module bank_sram import bank_pkg::*; #(
  parameter logic [6:0] SEED = 7'h5a
) (
  input  wire logic      clk_i,
  input  wire logic      rst_i,
  input  wire logic      req_i,
  input  wire bank_req_t req_data_i,
  output logic           gnt_o,
  output logic           rvalid_o,
  output bank_rsp_t      rsp_data_o
);

  bank_data_t mem_q [BankWords];
  word_idx_t  word_idx;
  logic [6:0] lfsr_q;
  logic       throttle;
  logic       rvalid_q;
  bank_data_t rdata_q;

  // Word index sits above the bank and byte offset bits.
  assign word_idx = req_data_i.addr[WordLsb +: $bits(word_idx_t)];

  // Maximal length 7-bit LFSR, taps at bits 7 and 6.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q <= SEED;
    end else begin
      lfsr_q <= {lfsr_q[5:0], lfsr_q[6] ^ lfsr_q[5]};
    end
  end

  // Open in about three cycles of four.
  assign throttle = lfsr_q[0] | lfsr_q[1];
  assign gnt_o    = req_i && throttle;

  // Byte-strobed write on the grant edge.
  always_ff @(posedge clk_i) begin
    if (gnt_o && req_data_i.we) begin
      for (int b = 0; b < BankStrbWidth; b++) begin
        if (req_data_i.strb[b]) begin
          mem_q[word_idx][b*8 +: 8] <= req_data_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt_o;
    end
  end

  // Read data, old contents on a write.
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      rdata_q <= mem_q[word_idx];
    end
  end

  assign rvalid_o         = rvalid_q;
  assign rsp_data_o.rdata = rdata_q;

  a_rvalid_after_gnt : assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_o |-> $past(gnt_o))
    else $error("bank response without a grant");

endmodule

`default_nettype wire

// ==== src/mem_to_banks.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_to_banks import mem_bus_pkg::*, bank_pkg::*; (
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  input  wire logic                       req_i,
  input  wire mem_req_t                   req_data_i,
  output logic                            gnt_o,
  output logic                            rvalid_o,
  output mem_rsp_t                        rsp_data_o,
  output bank_mask_t                      bank_req_o,
  output bank_req_t  [NumBanks-1:0]       bank_req_data_o,
  input  wire bank_mask_t                 bank_gnt_i,
  input  wire bank_mask_t                 bank_rvalid_i,
  input  wire bank_rsp_t [NumBanks-1:0]   bank_rsp_i
);

  logic                           push;
  bank_req_t  [NumBanks-1:0]      bank_req;
  bank_req_t  [NumBanks-1:0]      bank_head;
  bank_mask_t                     req_ready;
  bank_mask_t                     head_valid;
  bank_mask_t                     head_hidden;
  bank_mask_t                     head_pop;
  bank_mask_t                     zero_strb;
  bank_mask_t                     rsp_ready;
  bank_mask_t                     rsp_valid;
  bank_rsp_t  [NumBanks-1:0]      rsp_head;
  bank_data_t [NumBanks-1:0]      rsp_rdata;
  bank_mask_t                     credit_ok;
  credit_t    [NumBanks-1:0]      credit_q;
  logic                           zs_ready;
  logic                           zs_valid;
  bank_mask_t                     zs_head;
  logic                           zs_live;
  bank_mask_t                     dead;
  trans_cnt_t                     txn_cnt_q;

  // Clear the byte offset within the wide word.
  function automatic addr_t align_addr(input addr_t addr);
    return addr & ~addr_t'(StrbWidth - 1);
  endfunction

  assign push = req_i && gnt_o;

  for (genvar i = 0; i < NumBanks; i++) begin : gen_bank
    // Slice i of the wide request.
    assign bank_req[i].addr  = align_addr(req_data_i.addr) + addr_t'(i * BankStrbWidth);
    assign bank_req[i].wdata = req_data_i.wdata[i*BankDataWidth +: BankDataWidth];
    assign bank_req[i].strb  = req_data_i.strb[i*BankStrbWidth +: BankStrbWidth];
    assign bank_req[i].we    = req_data_i.we;
    assign zero_strb[i]      = req_data_i.we && (bank_req[i].strb == '0);

    stream_fifo #(
      .WIDTH ($bits(bank_req_t)),
      .DEPTH (FifoDepth)
    ) i_req_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .data_i  (bank_req[i]),
      .valid_i (push),
      .ready_o (req_ready[i]),
      .data_o  (bank_head[i]),
      .valid_o (head_valid[i]),
      .ready_i (head_pop[i])
    );

    // Zero-strobe writes drain here and never reach the bank.
    assign head_hidden[i]     = bank_head[i].we && (bank_head[i].strb == '0);
    assign bank_req_o[i]      = head_valid[i] && !head_hidden[i];
    assign head_pop[i]        = head_hidden[i] || bank_gnt_i[i];
    assign bank_req_data_o[i] = bank_head[i];

    stream_fifo #(
      .WIDTH ($bits(bank_rsp_t)),
      .DEPTH (FifoDepth)
    ) i_rsp_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .data_i  (bank_rsp_i[i]),
      .valid_i (bank_rvalid_i[i]),
      .ready_o (rsp_ready[i]),
      .data_o  (rsp_head[i]),
      .valid_o (rsp_valid[i]),
      .ready_i (rvalid_o && !dead[i])
    );
    assign rsp_rdata[i] = rsp_head[i].rdata;

    // Responses this bank still owes, bounded by its response FIFO depth.
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        credit_q[i] <= '0;
      end else begin
        credit_q[i] <= credit_q[i] + credit_t'(push && !zero_strb[i])
                                   - credit_t'(rvalid_o && !dead[i]);
      end
    end
    assign credit_ok[i] = (credit_q[i] < credit_t'(FifoDepth));

    a_rsp_fifo_room : assert property (@(posedge clk_i) disable iff (rst_i)
      bank_rvalid_i[i] |-> rsp_ready[i])
      else $error("bank %0d answered into a full response FIFO", i);
  end

  // Accept only when every slice and its answer have a place to go.
  assign gnt_o = (&req_ready) && (&rsp_ready) && zs_ready && (&credit_ok);

  // Mask of hidden slices, one entry per accepted transfer.
  stream_fifo #(
    .WIDTH (NumBanks),
    .DEPTH (MaxTrans + 1)
  ) i_zs_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .data_i  (zero_strb),
    .valid_i (push),
    .ready_o (zs_ready),
    .data_o  (zs_head),
    .valid_o (zs_valid),
    .ready_i (rvalid_o)
  );

  // Transfers in flight, keeps a transfer from answering in its own cycle.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      txn_cnt_q <= '0;
    end else begin
      txn_cnt_q <= txn_cnt_q + trans_cnt_t'(push) - trans_cnt_t'(rvalid_o);
    end
  end

  assign zs_live = (txn_cnt_q != '0);
  assign dead    = zs_head & {NumBanks{zs_live}};

  // Oldest transfer completes once all its live slices have answered.
  assign rvalid_o         = zs_live && (&(rsp_valid | dead));
  assign rsp_data_o.rdata = rsp_rdata;

  a_zs_not_empty : assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_o |-> zs_valid)
    else $error("response popped an empty zero-strobe FIFO");

endmodule

`default_nettype wire

// ==== src/mem_banked_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_banked_top import mem_bus_pkg::*, bank_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_i,
  input  wire logic     req_i,
  input  wire mem_req_t req_data_i,
  output logic          gnt_o,
  output logic          rvalid_o,
  output mem_rsp_t      rsp_data_o
);

  bank_mask_t                bank_req;
  bank_req_t  [NumBanks-1:0] bank_req_data;
  bank_mask_t                bank_gnt;
  bank_mask_t                bank_rvalid;
  bank_rsp_t  [NumBanks-1:0] bank_rsp;

  mem_to_banks i_mem_to_banks (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req_i           (req_i),
    .req_data_i      (req_data_i),
    .gnt_o           (gnt_o),
    .rvalid_o        (rvalid_o),
    .rsp_data_o      (rsp_data_o),
    .bank_req_o      (bank_req),
    .bank_req_data_o (bank_req_data),
    .bank_gnt_i      (bank_gnt),
    .bank_rvalid_i   (bank_rvalid),
    .bank_rsp_i      (bank_rsp)
  );

  // Distinct seeds keep the banks out of step.
  for (genvar i = 0; i < NumBanks; i++) begin : gen_banks
    bank_sram #(
      .SEED (7'(17 + 23 * i))
    ) i_bank_sram (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .req_i      (bank_req[i]),
      .req_data_i (bank_req_data[i]),
      .gnt_o      (bank_gnt[i]),
      .rvalid_o   (bank_rvalid[i]),
      .rsp_data_o (bank_rsp[i])
    );
  end

endmodule

`default_nettype wire

// ==== tb/tb_mem_banked_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_banked_top import mem_bus_pkg::*; ();

  localparam int unsigned PoolSize      = 32;
  localparam int unsigned MixedOps      = 64;
  // Fill and read back, partial strobe, zero strobe, then the mixed burst.
  localparam int unsigned NumRequests   = 2 * PoolSize + 3 + 5 + MixedOps;
  localparam int unsigned TimeoutCycles = 40 * NumRequests + 200;

  // One expected response. Read data is checked only for reads.
  typedef struct packed {
    logic       is_read;
    wide_data_t rdata;
  } expect_t;

  logic       clk;
  logic       rst;
  logic       req;
  mem_req_t   req_data;
  logic       gnt;
  logic       rvalid;
  mem_rsp_t   rsp_data;

  expect_t     exp_q [$];
  expect_t     mon_entry;
  // Shadow memory of wide words, keyed by the aligned byte address.
  wide_data_t  shadow [addr_t];
  addr_t       addr_pool [PoolSize];
  integer      seed;
  int unsigned mismatch_cnt = 0;
  int unsigned fault_cnt    = 0;
  int unsigned rsp_cnt      = 0;
  int unsigned cycle_cnt    = 0;
  int unsigned stall_cnt    = 0;

  mem_banked_top UUT (
    .clk_i      (clk),
    .rst_i      (rst),
    .req_i      (req),
    .req_data_i (req_data),
    .gnt_o      (gnt),
    .rvalid_o   (rvalid),
    .rsp_data_o (rsp_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_data(input string name, input wide_data_t exp, input wide_data_t act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("mismatch at %0t ns: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("mismatch at %0t ns: %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic print_summary();
    $display("Errors: %0d mismatches, %0d other failures, %0d responses seen",
             mismatch_cnt, fault_cnt, rsp_cnt);
  endtask

  // Bytes with a set strobe take the new value, the rest keep the old one.
  function automatic wide_data_t merge_bytes(input wide_data_t old_word, input wide_data_t wdata,
                                             input wide_strb_t strb);
    wide_data_t word;
    word = old_word;
    for (int b = 0; b < StrbWidth; b++) begin
      if (strb[b]) begin
        word[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return word;
  endfunction

  // Holds the request until a grant, then records what the response must be.
  // Called and returns 1 ns after a rising edge.
  task automatic issue(input mem_req_t rq);
    logic    granted;
    addr_t   key;
    expect_t entry;
    req      = 1'b1;
    req_data = rq;
    granted  = 1'b0;
    while (!granted) begin
      @(negedge clk);
      granted = gnt;
      if (!granted) begin
        stall_cnt++;
      end
      @(posedge clk);
      #1;
    end
    // Transfer took place on the last rising edge.
    key = rq.addr & ~addr_t'(StrbWidth - 1);
    entry.is_read = !rq.we;
    entry.rdata   = shadow[key];
    if (rq.we) begin
      shadow[key] = merge_bytes(shadow[key], rq.wdata, rq.strb);
    end
    exp_q.push_back(entry);
    req      = 1'b0;
    req_data = '0;
  endtask

  task automatic write_word(input addr_t addr, input wide_data_t wdata, input wide_strb_t strb);
    mem_req_t rq;
    rq.addr  = addr;
    rq.wdata = wdata;
    rq.strb  = strb;
    rq.we    = 1'b1;
    issue(rq);
  endtask

  task automatic read_word(input addr_t addr);
    mem_req_t rq;
    rq.addr  = addr;
    rq.wdata = '0;
    rq.strb  = '0;
    rq.we    = 1'b0;
    issue(rq);
  endtask

  // Drain all outstanding responses, then idle to catch stray ones.
  task automatic wait_idle();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    repeat (4) @(posedge clk);
    #1;
  endtask

  task automatic test_reset();
    $display("Test: reset");
    @(posedge clk);
    @(negedge clk);
    check_bit("rvalid_o", 1'b0, rvalid);
    @(posedge clk);
    #1;
    rst = 1'b0;
    // Grant must be up right after reset with nothing pending.
    @(negedge clk);
    check_bit("gnt_o", 1'b1, gnt);
    check_bit("rvalid_o", 1'b0, rvalid);
    @(posedge clk);
    #1;
  endtask

  task automatic test_fill_and_read();
    logic [7:0] idx;
    $display("Test: full strobe fill and read back");
    for (int i = 0; i < PoolSize; i++) begin
      // Distinct word indices with the bits above them left at zero.
      idx          = 8'(i * 8 + ($random(seed) & 7));
      addr_pool[i] = {5'b0, idx, 3'b000};
      write_word(addr_pool[i] | addr_t'($random(seed) & 7), {$random(seed), $random(seed)},
                 8'hff);
    end
    for (int i = 0; i < PoolSize; i++) begin
      read_word(addr_pool[i]);
    end
    wait_idle();
  endtask

  task automatic test_partial_strobe();
    $display("Test: partial strobe write");
    write_word(addr_pool[3], 64'h0123_4567_89ab_cdef, 8'hff);
    write_word(addr_pool[3] + 16'd5, 64'hfedc_ba98_7654_3210, 8'b1010_0110);
    read_word(addr_pool[3]);
    wait_idle();
  endtask

  task automatic test_zero_strobe();
    int unsigned seen;
    $display("Test: zero strobe writes");
    write_word(addr_pool[5], 64'h1111_2222_3333_4444, 8'hff);
    wait_idle();
    seen = rsp_cnt;
    // All slices hidden yet exactly one response.
    write_word(addr_pool[5], 64'hdead_beef_dead_beef, 8'h00);
    wait_idle();
    if (rsp_cnt - seen != 1) begin
      fault_cnt++;
      $display("All-zero strobe write gave %0d responses instead of one", rsp_cnt - seen);
    end
    read_word(addr_pool[5]);
    // Slices 1 and 2 hidden, slices 0 and 3 written.
    write_word(addr_pool[5], 64'haaaa_bbbb_cccc_dddd, 8'b1100_0011);
    read_word(addr_pool[5]);
    wait_idle();
  endtask

  task automatic test_back_to_back();
    mem_req_t rq;
    $display("Test: back-to-back mixed traffic");
    stall_cnt = 0;
    for (int i = 0; i < MixedOps; i++) begin
      rq.we    = 1'($random(seed));
      rq.addr  = addr_pool[$random(seed) & 31] | addr_t'($random(seed) & 7);
      rq.wdata = {$random(seed), $random(seed)};
      rq.strb  = 8'($random(seed));
      issue(rq);
    end
    wait_idle();
    // Throttled banks must have pushed back on the wide port at least once.
    if (stall_cnt == 0) begin
      fault_cnt++;
      $display("gnt_o never dropped during back-to-back traffic");
    end
  endtask

  // Response monitor samples at the falling edge where outputs are stable.
  always @(negedge clk) begin
    if (!rst && rvalid === 1'b1) begin
      rsp_cnt++;
      if (exp_q.size() == 0) begin
        fault_cnt++;
        $display("Response at %0t ns arrived with no request waiting for it", $time);
      end else begin
        mon_entry = exp_q.pop_front();
        if (mon_entry.is_read) begin
          check_data("rsp_data_o.rdata", mon_entry.rdata, rsp_data.rdata);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      fault_cnt++;
      $display("Run stopped after %0d cycles with %0d responses still missing",
               cycle_cnt, exp_q.size());
      print_summary();
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    seed     = 38236;
    rst      = 1'b1;
    req      = 1'b0;
    req_data = '0;
    test_reset();
    test_fill_and_read();
    test_partial_strobe();
    test_zero_strobe();
    test_back_to_back();
    print_summary();
    if (mismatch_cnt + fault_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
src/mem_bus_pkg.sv
src/bank_pkg.sv
src/stream_fifo.sv
src/bank_sram.sv
src/mem_to_banks.sv
src/mem_banked_top.sv
tb/tb_mem_banked_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the banked memory testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mem_banked_top -f flist.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
exit 0
